// ==== hdl/irq_pkg.sv ====
/*
 * Shared definitions of the machine-mode interrupt path
 * Width typedefs, CSR addresses, legal interrupt mask,
 * reset values and the mtvec mode enum
 */

package irq_pkg;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Machine word for data, CSR contents and addresses
  typedef logic [31:0] word_t;
  // CSR address as found in the instruction
  typedef logic [11:0] csr_addr_t;
  // Interrupt number, one of 32 lines
  typedef logic [4:0]  irq_id_t;

  // Trap vector mode, low field of mtvec
  typedef enum logic [1:0] {
    MTVEC_DIRECT   = 2'd0,
    MTVEC_VECTORED = 2'd1
  } mtvec_mode_e;

  ////////////////////////////////////////
  // CSR addresses
  ////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MIP     = 12'h344;

  ////////////////////////////////////////
  // Field layout and reset values
  ////////////////////////////////////////

  // Software 3, timer 7, external 11, fast 16 to 31
  localparam word_t IRQ_MASK = 32'hFFFF_0888;

  // Global enable inside mstatus
  localparam int unsigned MSTATUS_MIE_BIT = 3;

  // Base field of mtvec starts here, 128-byte aligned
  localparam int unsigned MTVEC_BASE_LSB = 7;

  // Base 0 in direct mode
  localparam word_t MTVEC_RESET = 32'h0000_0000;

endpackage

// ==== hdl/irq_sync.sv ====
/*
 * Two-flop synchronizer for the external interrupt lines
 * Produces the pending word with reserved bits masked off
 */

module irq_sync (
  input  logic          clk_i,
  input  logic          rst_n_i,
  // Asynchronous interrupt lines
  input  irq_pkg::word_t irq_i,
  // Pending word towards CSRs and arbiter
  output irq_pkg::word_t mip_o
);

  import irq_pkg::*;

  // First stage may go metastable
  word_t sync_q1;
  // Second stage is stable and masked
  word_t sync_q2;

  ////////////////////////////////////////
  // Synchronizer stages
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= irq_i;
      // Reserved lines never become pending
      sync_q2 <= sync_q1 & IRQ_MASK;
    end
  end

  // Two edges from line to pending bit
  assign mip_o = sync_q2;

endmodule

// ==== hdl/irq_csr.sv ====
/*
 * Machine interrupt CSRs mstatus.MIE, mie and mtvec
 * Single-cycle write strobe with legalization
 * Combinational read multiplexer including mip
 */

module irq_csr (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Write strobe and access
  input  logic                  csr_we_i,
  input  irq_pkg::csr_addr_t    csr_addr_i,
  input  irq_pkg::word_t        csr_wdata_i,
  // Pending word from synchronizer
  input  irq_pkg::word_t        mip_i,
  // Read data
  output irq_pkg::word_t        csr_rdata_o,
  // Towards arbiter
  output irq_pkg::word_t        mie_o,
  output logic                  m_irq_enable_o,
  output irq_pkg::word_t        mtvec_base_o,
  output irq_pkg::mtvec_mode_e  mtvec_mode_o
);

  import irq_pkg::*;

  // Global enable bit of mstatus
  logic                        mstatus_mie_q;
  // Enable word, legal bits only
  word_t                       mie_q;
  // Upper bits of the trap vector
  logic [31:MTVEC_BASE_LSB]    mtvec_base_q;
  mtvec_mode_e                 mtvec_mode_q;
  // Mode after legalization of the write data
  mtvec_mode_e                 mtvec_mode_wr;

  ////////////////////////////////////////
  // Write legalization
  ////////////////////////////////////////

  // Reserved modes keep the current one
  always_comb begin
    case (csr_wdata_i[1:0])
      2'd0:    mtvec_mode_wr = MTVEC_DIRECT;
      2'd1:    mtvec_mode_wr = MTVEC_VECTORED;
      default: mtvec_mode_wr = mtvec_mode_q;
    endcase
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mstatus_mie_q <= 1'b0;
      mie_q         <= '0;
      mtvec_base_q  <= MTVEC_RESET[31:MTVEC_BASE_LSB];
      mtvec_mode_q  <= mtvec_mode_e'(MTVEC_RESET[1:0]);
    end else if (csr_we_i) begin
      case (csr_addr_i)
        // Only MIE is writable
        CSR_MSTATUS: mstatus_mie_q <= csr_wdata_i[MSTATUS_MIE_BIT];
        // Drop reserved enables
        CSR_MIE:     mie_q <= csr_wdata_i & IRQ_MASK;
        CSR_MTVEC: begin
          mtvec_base_q <= csr_wdata_i[31:MTVEC_BASE_LSB];
          mtvec_mode_q <= mtvec_mode_wr;
        end
        // mip is read-only, others ignored
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Outputs to arbiter
  ////////////////////////////////////////

  assign m_irq_enable_o = mstatus_mie_q;
  assign mie_o          = mie_q;
  // Low bits of the base read as zero
  assign mtvec_base_o   = {mtvec_base_q, {MTVEC_BASE_LSB{1'b0}}};
  assign mtvec_mode_o   = mtvec_mode_q;

  ////////////////////////////////////////
  // Read multiplexer
  ////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      CSR_MSTATUS: csr_rdata_o[MSTATUS_MIE_BIT] = mstatus_mie_q;
      CSR_MIE:     csr_rdata_o = mie_q;
      // Base and mode share the word
      CSR_MTVEC:   csr_rdata_o = mtvec_base_o | word_t'(mtvec_mode_q);
      CSR_MIP:     csr_rdata_o = mip_i;
      // Unknown address reads zero
      default:     csr_rdata_o = '0;
    endcase
  end

endmodule

// ==== hdl/irq_arbiter.sv ====
/*
 * Interrupt arbiter
 * Enable masking, fixed priority pick and handler address
 * All outputs registered
 */

module irq_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Pending and enabled words
  input  irq_pkg::word_t        mip_i,
  input  irq_pkg::word_t        mie_i,
  // Global enable from mstatus
  input  logic                  m_irq_enable_i,
  // Trap vector
  input  irq_pkg::word_t        mtvec_base_i,
  input  irq_pkg::mtvec_mode_e  mtvec_mode_i,
  // Request towards the controller
  output logic                  irq_req_o,
  output logic                  irq_wu_o,
  output irq_pkg::irq_id_t      irq_id_o,
  output irq_pkg::word_t        irq_target_o
);

  import irq_pkg::*;

  // Pending and enabled
  word_t   irq_active;
  logic    irq_wu_d;
  logic    irq_req_d;
  irq_id_t irq_id_d;
  word_t   irq_target_d;

  // Wake-up ignores the global enable
  assign irq_active = mip_i & mie_i;
  assign irq_wu_d   = |irq_active;
  assign irq_req_d  = irq_wu_d & m_irq_enable_i;

  ////////////////////////////////////////
  // Priority selection
  ////////////////////////////////////////

  // Later assignments win
  // Order low to high is timer, software, external, fast
  always_comb begin
    irq_id_d = '0;
    if (irq_active[7]) irq_id_d = irq_id_t'(7);
    if (irq_active[3]) irq_id_d = irq_id_t'(3);
    if (irq_active[11]) irq_id_d = irq_id_t'(11);
    // Highest fast line last so it wins
    for (int i = 16; i < 32; i++) begin
      if (irq_active[i]) irq_id_d = irq_id_t'(i);
    end
  end

  ////////////////////////////////////////
  // Handler address
  ////////////////////////////////////////

  // Vectored adds four bytes per id
  always_comb begin
    irq_target_d = '0;
    if (irq_wu_d) begin
      if (mtvec_mode_i == MTVEC_VECTORED)
        irq_target_d = mtvec_base_i + word_t'({irq_id_d, 2'b00});
      else
        irq_target_d = mtvec_base_i;
    end
  end

  // Output stage, one cycle of latency
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_req_o    <= 1'b0;
      irq_wu_o     <= 1'b0;
      irq_id_o     <= '0;
      irq_target_o <= '0;
    end else begin
      irq_req_o    <= irq_req_d;
      irq_wu_o     <= irq_wu_d;
      irq_id_o     <= irq_id_d;
      irq_target_o <= irq_target_d;
    end
  end

endmodule

// ==== hdl/irq_unit.sv ====
/*
 * Machine-mode interrupt unit top level
 * Synchronizer, CSR block and arbiter
 */

module irq_unit (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // External interrupt lines
  input  irq_pkg::word_t     irq_i,
  // CSR write strobe and read port
  input  logic               csr_we_i,
  input  irq_pkg::csr_addr_t csr_addr_i,
  input  irq_pkg::word_t     csr_wdata_i,
  output irq_pkg::word_t     csr_rdata_o,
  // Interrupt request
  output logic               irq_req_o,
  output logic               irq_wu_o,
  output irq_pkg::irq_id_t   irq_id_o,
  output irq_pkg::word_t     irq_target_o
);

  import irq_pkg::*;

  // Synchronizer to CSRs and arbiter
  word_t       mip;
  // CSRs to arbiter
  word_t       mie;
  logic        m_irq_enable;
  word_t       mtvec_base;
  mtvec_mode_e mtvec_mode;

  ////////////////////////////////////////
  // Line synchronizer
  ////////////////////////////////////////

  irq_sync irq_sync_i (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .irq_i          ( irq_i        ),
    .mip_o          ( mip          )
  );

  ////////////////////////////////////////
  // Interrupt CSRs
  ////////////////////////////////////////

  irq_csr irq_csr_i (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .csr_we_i       ( csr_we_i     ),
    .csr_addr_i     ( csr_addr_i   ),
    .csr_wdata_i    ( csr_wdata_i  ),
    .mip_i          ( mip          ),
    .csr_rdata_o    ( csr_rdata_o  ),
    .mie_o          ( mie          ),
    .m_irq_enable_o ( m_irq_enable ),
    .mtvec_base_o   ( mtvec_base   ),
    .mtvec_mode_o   ( mtvec_mode   )
  );

  // Arbiter with registered request
  irq_arbiter irq_arbiter_i (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .mip_i          ( mip          ),
    .mie_i          ( mie          ),
    .m_irq_enable_i ( m_irq_enable ),
    .mtvec_base_i   ( mtvec_base   ),
    .mtvec_mode_i   ( mtvec_mode   ),
    .irq_req_o      ( irq_req_o    ),
    .irq_wu_o       ( irq_wu_o     ),
    .irq_id_o       ( irq_id_o     ),
    .irq_target_o   ( irq_target_o )
  );

endmodule

// ==== test/tb_clock_gen.sv ====
/*
 * Testbench clock and reset generator
 * Free-running clock, synchronous active-low reset pulse
 */

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 40,
  parameter int unsigned RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Half period per toggle
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== test/irq_unit_checker.sv ====
/*
 * Concurrent assertions on the interrupt request outputs
 * Bound into the interrupt unit top level
 */

module irq_unit_checker (
  input logic             clk_i,
  input logic             rst_n_i,
  input logic             irq_req_i,
  input logic             irq_wu_i,
  input irq_pkg::irq_id_t irq_id_i,
  input irq_pkg::word_t   irq_target_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertions so far
  int unsigned error_count = 0;

  ////////////////////////////////////////
  // Request consistency
  ////////////////////////////////////////

  // Request only on top of a wake-up
  req_needs_wu: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_req_i |-> irq_wu_i)
    else begin
      $error("irq_req_o high while irq_wu_o is low");
      error_count++;
    end

  // Handler addresses are word aligned
  target_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_target_i[1:0] == 2'b00)
    else begin
      $error("irq_target_o not 4-byte aligned");
      error_count++;
    end

  // Idle id is zero
  id_zero_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !irq_wu_i |-> irq_id_i == '0)
    else begin
      $error("irq_id_o nonzero without wake-up");
      error_count++;
    end

  ////////////////////////////////////////
  // Reset
  ////////////////////////////////////////

  // A reset edge clears the output stage
  outputs_cleared: assert property (@(posedge clk_i)
    !rst_n_i |=> (!irq_req_i && !irq_wu_i && irq_id_i == '0 && irq_target_i == '0))
    else begin
      $error("outputs not zero after a reset edge");
      error_count++;
    end

endmodule

// ==== test/irq_unit_tb.sv ====
/*
 * Table-driven testbench of the interrupt unit
 * CSR strobes, line patterns, LFSR stimulus, reference model
 * Watchdog and per-test report
 */

module irq_unit_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import irq_pkg::*;

  localparam int unsigned PERIOD_NS    = 40;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned NUM_ROWS     = 16;
  localparam word_t       LFSR_SEED    = 32'd92;
  // Taps of x^32 + x^22 + x^2 + x + 1 in right-shifting form
  localparam word_t       LFSR_TAPS    = 32'h8020_0003;

  typedef struct packed {
    logic    req;
    logic    wu;
    irq_id_t id;
    word_t   target;
  } expect_t;

  logic clk, rst_n, csr_we, irq_req, irq_wu;
  word_t irq, csr_wdata, csr_rdata, irq_target;
  csr_addr_t csr_addr;
  irq_id_t irq_id;

  // Stimulus and expectation table
  string   tbl_name   [NUM_ROWS];
  word_t   tbl_mstatus[NUM_ROWS];
  word_t   tbl_mie    [NUM_ROWS];
  word_t   tbl_mtvec  [NUM_ROWS];
  word_t   tbl_irq    [NUM_ROWS];
  bit      tbl_rand   [NUM_ROWS];
  expect_t tbl_exp    [NUM_ROWS];

  word_t       lfsr_state = LFSR_SEED;
  mtvec_mode_e model_mode;
  int          test_errors, pass_count, fail_count;

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  irq_unit DUT (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .irq_i        ( irq        ),
    .csr_we_i     ( csr_we     ),
    .csr_addr_i   ( csr_addr   ),
    .csr_wdata_i  ( csr_wdata  ),
    .csr_rdata_o  ( csr_rdata  ),
    .irq_req_o    ( irq_req    ),
    .irq_wu_o     ( irq_wu     ),
    .irq_id_o     ( irq_id     ),
    .irq_target_o ( irq_target )
  );

  bind irq_unit irq_unit_checker irq_checker_i (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .irq_req_i    ( irq_req_o    ),
    .irq_wu_i     ( irq_wu_o     ),
    .irq_id_i     ( irq_id_o     ),
    .irq_target_i ( irq_target_o )
  );

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic word_t lfsr_next(word_t s);
    lfsr_next = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic draw_word(output word_t w);
    int i;
    for (i = 0; i < 32; i++) begin
      w[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic word_t base_of(word_t w);
    base_of = w & ~((word_t'(1) << MTVEC_BASE_LSB) - 1);
  endfunction

  // Priority 31 down to 16 then 11, 3 and 7
  function automatic expect_t reference_model(word_t pend, word_t en, logic gie,
                                              word_t base, mtvec_mode_e mode);
    int      order[19];
    int      k;
    logic    found;
    word_t   active;
    expect_t r;
    r = '0;
    found = 1'b0;
    active = pend & en;
    for (k = 0; k < 16; k++) order[k] = 31 - k;
    order[16] = 11;
    order[17] = 3;
    order[18] = 7;
    r.wu = |active;
    r.req = r.wu & gie;
    for (k = 0; k < 19; k++) begin
      if (!found && active[order[k]]) begin
        r.id = irq_id_t'(order[k]);
        found = 1'b1;
      end
    end
    if (r.wu) r.target = (mode == MTVEC_VECTORED) ? base + (word_t'(r.id) << 2) : base;
    return r;
  endfunction

  task automatic set_row(int i, string name, word_t mst, word_t mie, word_t mtv, word_t lines,
                         bit rnd, logic req, logic wu, int id, word_t tgt);
    tbl_name[i]    = name;
    tbl_mstatus[i] = mst;
    tbl_mie[i]     = mie;
    tbl_mtvec[i]   = mtv;
    tbl_irq[i]     = lines;
    tbl_rand[i]    = rnd;
    tbl_exp[i]     = '{req: req, wu: wu, id: irq_id_t'(id), target: tgt};
  endtask

  task automatic load_table();
    set_row(0, "legal_mie", '1, '1, 32'h0, 32'h0, 0, 0, 0, 0, 32'h0);
    set_row(1, "reserved_lines", 32'h8, '1, 32'h0, 32'h0000_F777, 0, 0, 0, 0, 32'h0);
    set_row(2, "wake_no_gie", 32'h0, 32'h800, 32'h1000, 32'h800, 0, 0, 1, 11, 32'h1000);
    set_row(3, "gie_raises_req", 32'h8, 32'h800, 32'h1000, 32'h800, 0, 1, 1, 11, 32'h1000);
    set_row(4, "masked_by_mie", 32'h8, 32'h80, 32'h1000, 32'h800, 0, 0, 0, 0, 32'h0);
    set_row(5, "prio_fast", 32'h8, '1, 32'h2001, 32'h8000_0888, 0, 1, 1, 31, 32'h207C);
    set_row(6, "prio_external", 32'h8, '1, 32'h2001, 32'h888, 0, 1, 1, 11, 32'h202C);
    set_row(7, "prio_software", 32'h8, '1, 32'h2001, 32'h88, 0, 1, 1, 3, 32'h200C);
    set_row(8, "mode3_keeps_vec", 32'h8, '1, 32'h2003, 32'h80, 0, 1, 1, 7, 32'h201C);
    set_row(9, "direct_base", 32'h8, '1, 32'h4000, 32'h1_0000, 0, 1, 1, 16, 32'h4000);
    set_row(10, "mode3_keeps_dir", 32'h8, '1, 32'h4083, 32'h1_0000, 0, 1, 1, 16, 32'h4080);
    set_row(11, "vectored_id16", 32'h8, '1, 32'h4001, 32'h1_0000, 0, 1, 1, 16, 32'h4040);
    // Lines and enables from the LFSR
    set_row(12, "random_a", 32'h8, 32'h0, 32'h3001, 32'h0, 1, 0, 0, 0, 32'h0);
    set_row(13, "random_b", 32'h0, 32'h0, 32'h3001, 32'h0, 1, 0, 0, 0, 32'h0);
    set_row(14, "random_c", 32'h8, 32'h0, 32'h5000, 32'h0, 1, 0, 0, 0, 32'h0);
    set_row(15, "random_d", 32'h8, 32'h0, 32'h7F81, 32'h0, 1, 0, 0, 0, 32'h0);
  endtask

  ////////////////////////////////////////
  // Checking and driving
  ////////////////////////////////////////

  task automatic check_value(string name, string what, word_t expected, word_t actual);
    assert (actual === expected) else begin
      $display("ERR %s %s expected %h actual %h", name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_outputs(string name, expect_t e);
    check_value(name, "irq_req", word_t'(e.req), word_t'(irq_req));
    check_value(name, "irq_wu", word_t'(e.wu), word_t'(irq_wu));
    check_value(name, "irq_id", word_t'(e.id), word_t'(irq_id));
    check_value(name, "irq_target", e.target, irq_target);
  endtask

  task automatic close_test(string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("test %-16s ok", name);
    end else begin
      fail_count++;
      $display("test %-16s bad, %0d mismatches", name, test_errors);
    end
    test_errors = 0;
  endtask

  // Write lands at the next rising edge
  task automatic write_csr(csr_addr_t addr, word_t data);
    @(posedge clk);
    csr_we    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
  endtask

  task automatic check_reset();
    @(posedge clk);
    csr_addr <= CSR_MTVEC;
    @(negedge clk);
    check_outputs("reset", '0);
    check_value("reset", "mtvec", MTVEC_RESET, csr_rdata);
    close_test("reset");
  endtask

  task automatic run_row(int idx);
    word_t   lines;
    word_t   mie_val;
    expect_t e;
    lines   = tbl_irq[idx];
    mie_val = tbl_mie[idx];
    if (tbl_rand[idx]) begin
      draw_word(lines);
      draw_word(mie_val);
    end
    write_csr(CSR_MSTATUS, tbl_mstatus[idx]);
    write_csr(CSR_MIE, mie_val);
    write_csr(CSR_MTVEC, tbl_mtvec[idx]);
    // Reserved modes leave the mode alone
    if (tbl_mtvec[idx][1:0] == 2'd0) model_mode = MTVEC_DIRECT;
    if (tbl_mtvec[idx][1:0] == 2'd1) model_mode = MTVEC_VECTORED;
    e = tbl_rand[idx] ? reference_model(lines & IRQ_MASK, mie_val & IRQ_MASK,
                                        tbl_mstatus[idx][MSTATUS_MIE_BIT],
                                        base_of(tbl_mtvec[idx]), model_mode)
                      : tbl_exp[idx];
    @(posedge clk);
    csr_we   <= 1'b0;
    irq      <= lines;
    csr_addr <= CSR_MIE;
    @(negedge clk);
    check_value(tbl_name[idx], "mie", mie_val & IRQ_MASK, csr_rdata);
    @(posedge clk);
    csr_addr <= CSR_MSTATUS;
    @(negedge clk);
    check_value(tbl_name[idx], "mstatus", tbl_mstatus[idx] & (word_t'(1) << MSTATUS_MIE_BIT),
                csr_rdata);
    @(posedge clk);
    csr_addr <= CSR_MTVEC;
    @(negedge clk);
    check_value(tbl_name[idx], "mtvec", base_of(tbl_mtvec[idx]) | word_t'(model_mode), csr_rdata);
    // Third edge after the lines change
    @(posedge clk);
    csr_addr <= CSR_MIP;
    @(negedge clk);
    check_value(tbl_name[idx], "mip", lines & IRQ_MASK, csr_rdata);
    check_outputs(tbl_name[idx], e);
    close_test(tbl_name[idx]);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    irq       = '0;
    csr_we    = 1'b0;
    csr_addr  = '0;
    csr_wdata = '0;
    model_mode = mtvec_mode_e'(MTVEC_RESET[1:0]);
    load_table();
    wait (rst_n === 1'b1);
    check_reset();
    for (int r = 0; r < NUM_ROWS; r++) run_row(r);
    $display("tests %0d passed %0d failed %0d assertion errors %0d", NUM_ROWS + 1,
             pass_count, fail_count, DUT.irq_checker_i.error_count);
    if (fail_count == 0 && DUT.irq_checker_i.error_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // Ten cycles per row plus reset
  initial begin
    #((NUM_ROWS * 10 + RESET_CYCLES) * PERIOD_NS);
    $display("Run timed out before all tests finished");
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== build.f ====
hdl/irq_pkg.sv
hdl/irq_sync.sv
hdl/irq_csr.sv
hdl/irq_arbiter.sv
hdl/irq_unit.sv
test/tb_clock_gen.sv
test/irq_unit_checker.sv
test/irq_unit_tb.sv

// ==== Bender.yml ====
package:
  name: irq_unit

sources:
  # Interrupt path RTL
  - files:
      - hdl/irq_pkg.sv
      - hdl/irq_sync.sv
      - hdl/irq_csr.sv
      - hdl/irq_arbiter.sv
      - hdl/irq_unit.sv

  # Testbench
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/irq_unit_checker.sv
      - test/irq_unit_tb.sv
